// File: Bender.yml
package:
  name: csc_channel

sources:
  # RTL in compile order
  - files:
      - hw/csc_pkg.sv
      - hw/csc_mul.sv
      - hw/csc_add.sv
      - hw/csc_channel.sv

  # Testbench
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_csc_channel.sv

// File: hw/csc_add.sv
`default_nettype none

module csc_add #(
  parameter int delay_data_width = 16
) (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire csc_pkg::sm_word_t      data_1,
  input  wire csc_pkg::sm_word_t      data_2,
  input  wire csc_pkg::sm_word_t      data_3,
  input  wire csc_pkg::sm_word_t      data_4,
  output logic [csc_pkg::pix_w-1:0]   data_p,
  input  wire [delay_data_width-1:0]  ddata_in,
  output logic [delay_data_width-1:0] ddata_out
);

  // Bits above this index mean the result is 256 or more
  localparam int top_w = csc_pkg::frac_w + csc_pkg::pix_w;

  csc_pkg::sm_word_t             in_term [4];
  csc_pkg::sm_word_t             p1_term [4];
  csc_pkg::sm_word_t             p2_sum_a;
  csc_pkg::sm_word_t             p2_sum_b;
  csc_pkg::sm_word_t             p3_total;

  logic [delay_data_width-1:0]   p1_ddata;
  logic [delay_data_width-1:0]   p2_ddata;
  logic [delay_data_width-1:0]   p3_ddata;

  function automatic csc_pkg::sm_word_t to_twos(input csc_pkg::sm_word_t t);
    csc_pkg::sm_word_t r;
    r.raw = {1'b0, t.sm.mag};
    if (t.sm.neg) begin
      r.raw = ~r.raw + 1'b1;
    end
    return r;
  endfunction

  assign in_term[0] = data_1;
  assign in_term[1] = data_2;
  assign in_term[2] = data_3;
  assign in_term[3] = data_4;

  // Stage one, sign-magnitude to two's complement
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 4; i++) begin
        p1_term[i].raw <= '0;
      end
      p1_ddata <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        p1_term[i] <= to_twos(in_term[i]);
      end
      p1_ddata <= ddata_in;
    end
  end

  // Stage two, pair sums
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      p2_sum_a.raw <= '0;
      p2_sum_b.raw <= '0;
      p2_ddata     <= '0;
    end else begin
      p2_sum_a.raw <= p1_term[0].raw + p1_term[1].raw;
      p2_sum_b.raw <= p1_term[2].raw + p1_term[3].raw;
      p2_ddata     <= p1_ddata;
    end
  end

  // Stage three, total
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      p3_total.raw <= '0;
      p3_ddata     <= '0;
    end else begin
      p3_total.raw <= p2_sum_a.raw + p2_sum_b.raw;
      p3_ddata     <= p2_ddata;
    end
  end

  // Stage four, clamp below at zero and above at full scale
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data_p    <= '0;
      ddata_out <= '0;
    end else begin
      ddata_out <= p3_ddata;
      if (p3_total.raw[csc_pkg::sm_w-1]) begin
        data_p <= '0;
      end else if (p3_total.raw[csc_pkg::sm_w-2:top_w] == '0) begin
        data_p <= p3_total.raw[top_w-1:csc_pkg::frac_w];
      end else begin
        data_p <= '1;
      end
    end
  end

  // Headroom for the four-term sum relies on bit 23 staying clear
  a_term_headroom: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(data_1.sm.mag[csc_pkg::sm_w-2] || data_2.sm.mag[csc_pkg::sm_w-2] ||
      data_3.sm.mag[csc_pkg::sm_w-2] || data_4.sm.mag[csc_pkg::sm_w-2])
  );

endmodule

`default_nettype wire

// File: hw/csc_channel.sv
`default_nettype none

module csc_channel #(
  parameter int delay_data_width = 16
) (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire [csc_pkg::pix_w-1:0]    r,
  input  wire [csc_pkg::pix_w-1:0]    g,
  input  wire [csc_pkg::pix_w-1:0]    b,
  input  wire [csc_pkg::coef_w-1:0]   coef_r,
  input  wire [csc_pkg::coef_w-1:0]   coef_g,
  input  wire [csc_pkg::coef_w-1:0]   coef_b,
  input  wire csc_pkg::sm_word_t      offset,
  input  wire [delay_data_width-1:0]  ddata_in,
  output logic [csc_pkg::pix_w-1:0]   data_p,
  output logic [delay_data_width-1:0] ddata_out
);

  csc_pkg::sm_word_t           prod_r;
  csc_pkg::sm_word_t           prod_g;
  csc_pkg::sm_word_t           prod_b;

  logic [delay_data_width-1:0] d1_ddata;
  logic [delay_data_width-1:0] d2_ddata;

  // Products take two cycles
  csc_mul mul_r (
    .clk    (clk),
    .arst_n (arst_n),
    .pix    (r),
    .coef   (coef_r),
    .prod   (prod_r)
  );

  csc_mul mul_g (
    .clk    (clk),
    .arst_n (arst_n),
    .pix    (g),
    .coef   (coef_g),
    .prod   (prod_g)
  );

  csc_mul mul_b (
    .clk    (clk),
    .arst_n (arst_n),
    .pix    (b),
    .coef   (coef_b),
    .prod   (prod_b)
  );

  // Side data waits out the multiplier latency
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      d1_ddata <= '0;
      d2_ddata <= '0;
    end else begin
      d1_ddata <= ddata_in;
      d2_ddata <= d1_ddata;
    end
  end

  // Offset skips the multipliers, so it must be held steady while pixels flow
  csc_add #(
    .delay_data_width (delay_data_width)
  ) add (
    .clk       (clk),
    .arst_n    (arst_n),
    .data_1    (prod_r),
    .data_2    (prod_g),
    .data_3    (prod_b),
    .data_4    (offset),
    .data_p    (data_p),
    .ddata_in  (d2_ddata),
    .ddata_out (ddata_out)
  );

  // Side data leaves six cycles after entry, in step with its pixel
  a_ddata_latency: assert property (
    @(posedge clk) disable iff (!arst_n)
    $past(arst_n, 6) |-> (ddata_out == $past(ddata_in, 6))
  );

  // Zero pixels contribute nothing, so the result depends on offset alone
  a_offset_only: assert property (
    @(posedge clk) disable iff (!arst_n)
    (r == '0 && g == '0 && b == '0 && offset.sm.neg && $stable(offset)) |->
      ##6 (data_p == '0)
  );

endmodule

`default_nettype wire

// File: hw/csc_mul.sv
`default_nettype none

module csc_mul (
  input  wire                       clk,
  input  wire                       arst_n,
  input  wire [csc_pkg::pix_w-1:0]  pix,
  input  wire [csc_pkg::coef_w-1:0] coef,
  output csc_pkg::sm_word_t         prod
);

  // Coefficient magnitude, pixel nibble and partial product widths
  localparam int mag_w  = csc_pkg::coef_w - 1;
  localparam int nib_w  = csc_pkg::pix_w / 2;
  localparam int part_w = nib_w + mag_w;
  localparam int out_w  = csc_pkg::sm_w - 1;

  logic [mag_w-1:0]  coef_mag;
  logic              coef_neg;
  logic [nib_w-1:0]  pix_lo;
  logic [nib_w-1:0]  pix_hi;

  logic [part_w-1:0] p1_lo;
  logic [part_w-1:0] p1_hi;
  logic              p1_neg;

  logic [out_w-1:0]  mag_sum;
  logic              mag_zero;

  assign coef_neg = coef[csc_pkg::coef_w-1];
  assign coef_mag = coef[mag_w-1:0];

  assign pix_lo = pix[nib_w-1:0];
  assign pix_hi = pix[csc_pkg::pix_w-1:nib_w];

  // Stage one
  // Two nibble-wide products keep each multiplier small
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      p1_lo  <= '0;
      p1_hi  <= '0;
      p1_neg <= 1'b0;
    end else begin
      p1_lo  <= part_w'(pix_lo) * part_w'(coef_mag);
      p1_hi  <= part_w'(pix_hi) * part_w'(coef_mag);
      p1_neg <= coef_neg;
    end
  end

  // High nibble product weighs 2^nib_w more than the low one
  assign mag_sum  = (out_w'(p1_hi) << nib_w) + out_w'(p1_lo);
  assign mag_zero = (mag_sum == '0);

  // Stage two
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod.sm.neg <= 1'b0;
      prod.sm.mag <= '0;
    end else begin
      prod.sm.mag <= mag_sum;
      // Zero result is always positive zero
      prod.sm.neg <= p1_neg && !mag_zero;
    end
  end

  // A zero operand must come out as plain zero for either coefficient sign
  a_zero_prod_positive: assert property (
    @(posedge clk) disable iff (!arst_n)
    (pix == '0 || coef_mag == '0) |-> ##2 (prod.raw == '0)
  );

endmodule

`default_nettype wire

// File: hw/csc_pkg.sv
`default_nettype none

package csc_pkg;

  // Pixel component width
  localparam int pix_w = 8;

  // Sign bit plus 14-bit magnitude, magnitude below 4.0
  localparam int coef_w = 15;

  // Sign-magnitude term carried between the pipeline stages
  localparam int sm_w = 25;

  // Fixed-point fraction bits, also the low edge of the output window
  localparam int frac_w = 12;

  // One 25-bit word seen two ways
  // raw holds two's complement sums, sm splits sign from magnitude
  typedef union packed {
    logic [sm_w-1:0] raw;
    struct packed {
      logic            neg;
      logic [sm_w-2:0] mag;
    } sm;
  } sm_word_t;

endpackage

`default_nettype wire

// File: sources.f
+incdir+verif
hw/csc_pkg.sv
hw/csc_mul.sv
hw/csc_add.sv
hw/csc_channel.sv
verif/tb_csc_channel.sv

// File: verif/tb_csc_vectors.svh
`ifndef TB_CSC_VECTORS_SVH
`define TB_CSC_VECTORS_SVH

// Columns are r, g, b, coef_r, coef_g, coef_b, offset (sign-magnitude raw), ddata, data_p
// Coefficients are sign plus 14-bit magnitude with 12 fraction bits
task automatic load_table();
  // BT.601 luma, zero offset
  add_row(8'd0,   8'd0,   8'd0,   15'h04C9, 15'h0964, 15'h01D3, 25'h0000000, 16'h1001, 8'd0);
  add_row(8'd255, 8'd255, 8'd255, 15'h04C9, 15'h0964, 15'h01D3, 25'h0000000, 16'h2002, 8'd255);
  add_row(8'd255, 8'd0,   8'd0,   15'h04C9, 15'h0964, 15'h01D3, 25'h0000000, 16'h3003, 8'd76);
  add_row(8'd0,   8'd255, 8'd0,   15'h04C9, 15'h0964, 15'h01D3, 25'h0000000, 16'h4004, 8'd149);
  add_row(8'd0,   8'd0,   8'd255, 15'h04C9, 15'h0964, 15'h01D3, 25'h0000000, 16'h5005, 8'd29);
  add_row(8'd128, 8'd128, 8'd128, 15'h04C9, 15'h0964, 15'h01D3, 25'h0000000, 16'hA5A5, 8'd128);
  add_row(8'd100, 8'd150, 8'd200, 15'h04C9, 15'h0964, 15'h01D3, 25'h0000000, 16'hBEEF, 8'd140);
  add_row(8'd16,  8'd32,  8'd64,  15'h04C9, 15'h0964, 15'h01D3, 25'h0000000, 16'h0F0F, 8'd30);
  add_row(8'd1,   8'd1,   8'd1,   15'h04C9, 15'h0964, 15'h01D3, 25'h0000000, 16'hFFFF, 8'd1);
  add_row(8'd200, 8'd50,  8'd10,  15'h04C9, 15'h0964, 15'h01D3, 25'h0000000, 16'h8001, 8'd90);

  // Coefficients -1.0, -0.5, +0.25 and offset -10.0
  add_row(8'd10,  8'd20,  8'd30,  15'h5000, 15'h4800, 15'h0400, 25'h100A000, 16'h1234, 8'd0);
  add_row(8'd0,   8'd0,   8'd255, 15'h5000, 15'h4800, 15'h0400, 25'h100A000, 16'h2345, 8'd53);
  add_row(8'd0,   8'd0,   8'd40,  15'h5000, 15'h4800, 15'h0400, 25'h100A000, 16'h3456, 8'd0);
  add_row(8'd0,   8'd0,   8'd44,  15'h5000, 15'h4800, 15'h0400, 25'h100A000, 16'h4567, 8'd1);
  add_row(8'd255, 8'd0,   8'd255, 15'h5000, 15'h4800, 15'h0400, 25'h100A000, 16'h5678, 8'd0);
  add_row(8'd0,   8'd0,   8'd0,   15'h5000, 15'h4800, 15'h0400, 25'h100A000, 16'h6789, 8'd0);

  // All coefficients 3.5 and offset 256.0, always above full scale
  add_row(8'd0,   8'd0,   8'd0,   15'h3800, 15'h3800, 15'h3800, 25'h0100000, 16'h0101, 8'd255);
  add_row(8'd10,  8'd10,  8'd10,  15'h3800, 15'h3800, 15'h3800, 25'h0100000, 16'h0202, 8'd255);
  add_row(8'd255, 8'd255, 8'd255, 15'h3800, 15'h3800, 15'h3800, 25'h0100000, 16'h0303, 8'd255);

  // Offset 254.9375 with fine steps, around the 255 and 256 boundaries
  add_row(8'd0,   8'd0,   8'd0,   15'h0001, 15'h0001, 15'h1000, 25'h00FEF00, 16'hC001, 8'd254);
  add_row(8'd254, 8'd1,   8'd0,   15'h0001, 15'h0001, 15'h1000, 25'h00FEF00, 16'hC002, 8'd254);
  add_row(8'd255, 8'd1,   8'd0,   15'h0001, 15'h0001, 15'h1000, 25'h00FEF00, 16'hC003, 8'd255);
  add_row(8'd0,   8'd0,   8'd1,   15'h0001, 15'h0001, 15'h1000, 25'h00FEF00, 16'hC004, 8'd255);
  add_row(8'd255, 8'd0,   8'd1,   15'h0001, 15'h0001, 15'h1000, 25'h00FEF00, 16'hC005, 8'd255);
  add_row(8'd255, 8'd1,   8'd1,   15'h0001, 15'h0001, 15'h1000, 25'h00FEF00, 16'hC006, 8'd255);
  add_row(8'd255, 8'd255, 8'd1,   15'h0001, 15'h0001, 15'h1000, 25'h00FEF00, 16'hC007, 8'd255);

  // Negative coefficients and offset 100.03, zero pixels leave the offset alone
  add_row(8'd0,   8'd0,   8'd0,   15'h6000, 15'h5000, 15'h4800, 25'h006407B, 16'hD001, 8'd100);
  add_row(8'd0,   8'd0,   8'd2,   15'h6000, 15'h5000, 15'h4800, 25'h006407B, 16'hD002, 8'd99);
  add_row(8'd1,   8'd0,   8'd0,   15'h6000, 15'h5000, 15'h4800, 25'h006407B, 16'hD003, 8'd98);
  add_row(8'd0,   8'd3,   8'd0,   15'h6000, 15'h5000, 15'h4800, 25'h006407B, 16'hD004, 8'd97);
  add_row(8'd0,   8'd0,   8'd0,   15'h6000, 15'h5000, 15'h4800, 25'h006407B, 16'hD005, 8'd100);
  add_row(8'd51,  8'd0,   8'd0,   15'h6000, 15'h5000, 15'h4800, 25'h006407B, 16'hD006, 8'd0);
endtask

`endif

// File: verif/tb_csc_channel.sv
`default_nettype none

module tb_csc_channel;

  localparam int dd_w        = 16;
  localparam int cw          = csc_pkg::coef_w;
  localparam int sw          = csc_pkg::sm_w;
  localparam int n_random    = 40;
  localparam int drain_limit = 20;
  localparam int run_limit   = 2000;
  // Falling edges from driving a pixel to seeing its result
  localparam int out_lag     = 6;
  localparam logic [csc_pkg::pix_w-1:0] idle_pix = 8'h01;

  typedef struct packed {
    logic [csc_pkg::pix_w-1:0]  r;
    logic [csc_pkg::pix_w-1:0]  g;
    logic [csc_pkg::pix_w-1:0]  b;
    logic [cw-1:0]              cr;
    logic [cw-1:0]              cg;
    logic [cw-1:0]              cb;
    logic [sw-1:0]              off;
    logic [dd_w-1:0]            dd;
    logic [csc_pkg::pix_w-1:0]  exp_p;
  } row_t;

  logic                       clk = 1'b0;
  logic                       arst_n;
  logic [csc_pkg::pix_w-1:0]  r;
  logic [csc_pkg::pix_w-1:0]  g;
  logic [csc_pkg::pix_w-1:0]  b;
  logic [cw-1:0]              coef_r;
  logic [cw-1:0]              coef_g;
  logic [cw-1:0]              coef_b;
  csc_pkg::sm_word_t          offset;
  logic [dd_w-1:0]            ddata_in;
  wire  [csc_pkg::pix_w-1:0]  data_p;
  wire  [dd_w-1:0]            ddata_out;

  int cyc  = 0;
  int seed = 32'h501f_3637;

  row_t                      tab [$];
  logic [csc_pkg::pix_w-1:0] exp_p_q [$];
  logic [dd_w-1:0]           exp_d_q [$];
  int                        due_q [$];

  csc_channel #(
    .delay_data_width (dd_w)
  ) dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .r         (r),
    .g         (g),
    .b         (b),
    .coef_r    (coef_r),
    .coef_g    (coef_g),
    .coef_b    (coef_b),
    .offset    (offset),
    .ddata_in  (ddata_in),
    .data_p    (data_p),
    .ddata_out (ddata_out)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  function automatic longint sm_value(input logic neg, input longint mag);
    return neg ? -mag : mag;
  endfunction

  // Expected pixel from the signed sum of all four terms
  function automatic int ref_pixel(input row_t row);
    longint s;
    longint q;
    s = sm_value(row.cr[cw-1], longint'(row.r) * longint'(row.cr[cw-2:0]))
      + sm_value(row.cg[cw-1], longint'(row.g) * longint'(row.cg[cw-2:0]))
      + sm_value(row.cb[cw-1], longint'(row.b) * longint'(row.cb[cw-2:0]))
      + sm_value(row.off[sw-1], longint'(row.off[sw-2:0]));
    if (s < 0) begin
      return 0;
    end
    q = s / (longint'(1) << csc_pkg::frac_w);
    if (q >= 256) begin
      return 255;
    end
    return int'(q);
  endfunction

  function automatic bit same_settings(input row_t a, input row_t c);
    return {a.cr, a.cg, a.cb, a.off} == {c.cr, c.cg, c.cb, c.off};
  endfunction

  task automatic add_row(
    input logic [csc_pkg::pix_w-1:0] pr,
    input logic [csc_pkg::pix_w-1:0] pg,
    input logic [csc_pkg::pix_w-1:0] pb,
    input logic [cw-1:0]             cr,
    input logic [cw-1:0]             cg,
    input logic [cw-1:0]             cb,
    input logic [sw-1:0]             off,
    input logic [dd_w-1:0]           dd,
    input logic [csc_pkg::pix_w-1:0] exp_p
  );
    row_t row;
    row = '{r: pr, g: pg, b: pb, cr: cr, cg: cg, cb: cb, off: off, dd: dd, exp_p: exp_p};
    tab.push_back(row);
  endtask

  `include "tb_csc_vectors.svh"

  task automatic check_idle_zero();
    assert (data_p === '0) else
      stop_on_error($sformatf("CHECK FAILED t=%0t data_p expected 0 got %0d", $time, data_p));
    assert (ddata_out === '0) else
      stop_on_error($sformatf("CHECK FAILED t=%0t ddata_out expected 0 got %0h",
                              $time, ddata_out));
  endtask

  // Compare every result whose pixel entered out_lag edges ago
  task automatic check_due();
    logic [csc_pkg::pix_w-1:0] exp_p;
    logic [dd_w-1:0]           exp_d;
    while (due_q.size() > 0 && due_q[0] <= cyc) begin
      exp_p = exp_p_q.pop_front();
      exp_d = exp_d_q.pop_front();
      void'(due_q.pop_front());
      assert (data_p === exp_p) else
        stop_on_error($sformatf("CHECK FAILED t=%0t data_p expected %0d got %0d",
                                $time, exp_p, data_p));
      assert (ddata_out === exp_d) else
        stop_on_error($sformatf("CHECK FAILED t=%0t ddata_out expected %0h got %0h",
                                $time, exp_d, ddata_out));
    end
  endtask

  task automatic next_cycle();
    @(negedge clk);
    check_due();
  endtask

  task automatic drive_row(input row_t row);
    r          = row.r;
    g          = row.g;
    b          = row.b;
    coef_r     = row.cr;
    coef_g     = row.cg;
    coef_b     = row.cb;
    offset.raw = row.off;
    ddata_in   = row.dd;
    exp_p_q.push_back(row.exp_p);
    exp_d_q.push_back(row.dd);
    due_q.push_back(cyc + out_lag);
  endtask

  // Unchecked filler pixels keep the clock running until every result is out
  task automatic drain();
    int waited;
    waited = 0;
    while (due_q.size() != 0 && waited < drain_limit) begin
      next_cycle();
      r        = idle_pix;
      g        = idle_pix;
      b        = idle_pix;
      ddata_in = '0;
      waited++;
    end
    if (due_q.size() != 0) begin
      stop_on_error($sformatf("pipeline still held %0d pixels after %0d cycles",
                              due_q.size(), drain_limit));
    end
  endtask

  initial begin : watchdog
    repeat (run_limit) @(posedge clk);
    stop_on_error("the run went past its cycle limit without finishing");
  end

  initial begin : main
    row_t        row;
    logic [31:0] rnd;
    arst_n     = 1'b0;
    r          = '0;
    g          = '0;
    b          = '0;
    coef_r     = '0;
    coef_g     = '0;
    coef_b     = '0;
    offset.raw = '0;
    ddata_in   = '0;

    load_table();
    // Random pixels and side data under the luma coefficients
    repeat (n_random) begin
      rnd       = $random(seed);
      row.r     = rnd[7:0];
      row.g     = rnd[15:8];
      row.b     = rnd[23:16];
      rnd       = $random(seed);
      row.dd    = rnd[dd_w-1:0];
      row.cr    = 15'h04C9;
      row.cg    = 15'h0964;
      row.cb    = 15'h01D3;
      row.off   = '0;
      row.exp_p = 8'(ref_pixel(row));
      tab.push_back(row);
    end

    repeat (10) begin
      @(negedge clk);
      check_idle_zero();
    end
    arst_n = 1'b1;
    // Nothing has entered yet
    repeat (8) begin
      @(negedge clk);
      check_idle_zero();
    end

    for (int i = 0; i < tab.size(); i++) begin
      assert (int'(tab[i].exp_p) == ref_pixel(tab[i])) else
        stop_on_error($sformatf("table row %0d lists %0d but the output rule gives %0d",
                                i, tab[i].exp_p, ref_pixel(tab[i])));
      if (i > 0 && !same_settings(tab[i], tab[i-1])) begin
        drain();
      end
      next_cycle();
      drive_row(tab[i]);
    end
    drain();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
